//--- logic/vpe_defs.svh
`ifndef VPE_DEFS_SVH
`define VPE_DEFS_SVH

// datapath widths
`define VPE_W_BITS          16  // weight and activation
`define VPE_CH              8   // activation channels
`define VPE_POS_BITS        3
`define VPE_ADDR_FIELD_BITS 7
`define VPE_ADDR_FIELDS     3

// entry store and scan geometry
`define VPE_DEPTH           64
`define VPE_IDX_BITS        7   // holds a full length plus one window
`define VPE_WIN             3
`define VPE_GROUP           3

// host port
`define VPE_AXI_ADDR_BITS   12

// register map, byte addresses
// entry n sits at 8n (low word) and 8n+4 (high word)
`define VPE_ENTRY_BASE      12'h000
`define VPE_ACT_BASE        12'h200  // one word per channel
`define VPE_LEN_ADDR        12'h300
`define VPE_START_ADDR      12'h304

`endif

//--- logic/vpe_pkg.sv
`default_nettype none

`include "vpe_defs.svh"

package vpe_pkg;

    // three packed address fields, field 0 in the low bits
    typedef logic [`VPE_ADDR_FIELDS-1:0][`VPE_ADDR_FIELD_BITS-1:0] addr_t;

    typedef struct packed {
        logic                     valid;
        addr_t                    addr;
        logic [`VPE_POS_BITS-1:0] pos;     // activation channel
        logic [`VPE_W_BITS-1:0]   weight;
    } entry_t;

    // one selected weight paired with its activation
    typedef struct packed {
        logic [`VPE_W_BITS-1:0] weight;
        logic [`VPE_W_BITS-1:0] act;
        addr_t                  addr;
    } item_t;

    typedef struct packed {
        logic  item_valid;
        logic  done;       // end of list, never together with item_valid
        item_t item;
    } scan_out_t;

    typedef struct packed {
        item_t [`VPE_GROUP-1:0] slot;
    } group_t;

    typedef enum logic {
        S_IDLE,
        S_RUN
    } scan_state_e;

    typedef enum logic {
        BANK_RIGHT,
        BANK_LEFT
    } bank_e;

endpackage

`default_nettype wire

//--- logic/vpe_cfg_slave.sv
`default_nettype none

`include "vpe_defs.svh"

module vpe_cfg_slave (
    input  wire logic                                 i_clk,
    input  wire logic                                 i_rst_n,
    // AXI4-Lite write channels
    input  wire logic                                 i_awvalid,
    input  wire logic [`VPE_AXI_ADDR_BITS-1:0]        i_awaddr,
    input  wire logic                                 i_wvalid,
    input  wire logic [31:0]                          i_wdata,
    input  wire logic                                 i_bready,
    output logic                                      o_awready,
    output logic                                      o_wready,
    output logic                                      o_bvalid,
    // scanner side
    input  wire logic [`VPE_IDX_BITS-1:0]             i_win_idx,
    output vpe_pkg::entry_t [`VPE_WIN-1:0]            o_window,
    output logic [`VPE_CH-1:0][`VPE_W_BITS-1:0]      o_act,
    output logic [`VPE_IDX_BITS-1:0]                  o_len,
    output logic                                      o_start
);

    localparam int ENTRY_AW = $clog2(`VPE_DEPTH);
    localparam int ADDR_BITS = $bits(vpe_pkg::addr_t);
    localparam int IDX_W = `VPE_IDX_BITS;
    localparam logic [`VPE_IDX_BITS-1:0] MAX_LEN = IDX_W'(`VPE_DEPTH);

    logic                                 wr_fire;
    logic                                 bvalid_q;
    logic                                 start_q;
    logic [`VPE_IDX_BITS-1:0]             len_q;
    logic [`VPE_AXI_ADDR_BITS-1:0]        entry_off;
    logic [`VPE_AXI_ADDR_BITS-1:0]        act_off;
    logic                                 entry_hit;
    logic                                 act_hit;
    logic                                 len_hit;
    logic                                 start_hit;
    logic [ENTRY_AW-1:0]                  wr_entry;
    logic [`VPE_POS_BITS-1:0]             wr_ch;

    vpe_pkg::entry_t                      entry_mem [`VPE_DEPTH];
    logic [`VPE_CH-1:0][`VPE_W_BITS-1:0]  act_q;

    // accept address and data together, one write in flight
    assign wr_fire   = i_awvalid && i_wvalid && !bvalid_q;
    assign o_awready = wr_fire;
    assign o_wready  = wr_fire;
    assign o_bvalid  = bvalid_q;

    // register map decode
    assign entry_off = i_awaddr - `VPE_ENTRY_BASE;
    assign act_off   = i_awaddr - `VPE_ACT_BASE;
    assign entry_hit = entry_off[`VPE_AXI_ADDR_BITS-1:ENTRY_AW+3] == '0;
    assign act_hit   = act_off[`VPE_AXI_ADDR_BITS-1:`VPE_POS_BITS+2] == '0;
    assign len_hit   = i_awaddr == `VPE_LEN_ADDR;
    assign start_hit = i_awaddr == `VPE_START_ADDR;
    assign wr_entry  = entry_off[3 +: ENTRY_AW];  // 8 bytes per entry
    assign wr_ch     = act_off[2 +: `VPE_POS_BITS];

    // entry store and activations
    always_ff @(posedge i_clk) begin
        if (wr_fire && entry_hit) begin
            if (entry_off[2]) begin  // high word
                entry_mem[wr_entry].addr <= i_wdata[ADDR_BITS-1:0];
            end else begin
                entry_mem[wr_entry].weight <= i_wdata[`VPE_W_BITS-1:0];
                entry_mem[wr_entry].pos    <= i_wdata[16 +: `VPE_POS_BITS];
                entry_mem[wr_entry].valid  <= i_wdata[31];
            end
        end
        if (wr_fire && act_hit) begin
            act_q[wr_ch] <= i_wdata[`VPE_W_BITS-1:0];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bvalid_q <= 1'b0;
            start_q  <= 1'b0;
            len_q    <= '0;
        end else begin
            start_q <= wr_fire && start_hit;  // single cycle
            if (wr_fire) begin
                bvalid_q <= 1'b1;
            end else if (i_bready) begin
                bvalid_q <= 1'b0;
            end
            if (wr_fire && len_hit) begin
                // clamp to store depth
                len_q <= (i_wdata > `VPE_DEPTH) ? MAX_LEN : i_wdata[`VPE_IDX_BITS-1:0];
            end
        end
    end

    // window read, entries past the length look empty
    for (genvar k = 0; k < `VPE_WIN; k++) begin : g_win
        localparam logic [`VPE_IDX_BITS-1:0] OFF = IDX_W'(k);

        logic [`VPE_IDX_BITS-1:0] rd_idx;
        vpe_pkg::entry_t          rd_ent;

        assign rd_idx = i_win_idx + OFF;
        assign rd_ent = entry_mem[rd_idx[ENTRY_AW-1:0]];  // wraps, masked below
        assign o_window[k] = '{
            valid:  rd_ent.valid && (rd_idx < len_q),
            addr:   rd_ent.addr,
            pos:    rd_ent.pos,
            weight: rd_ent.weight
        };
    end

    assign o_act   = act_q;
    assign o_len   = len_q;
    assign o_start = start_q;

endmodule

`default_nettype wire

//--- logic/vpe_window_scan.sv
`default_nettype none

`include "vpe_defs.svh"

module vpe_window_scan (
    input  wire logic                                 i_clk,
    input  wire logic                                 i_rst_n,
    input  wire logic                                 i_start,
    input  wire vpe_pkg::entry_t [`VPE_WIN-1:0]       i_window,
    input  wire logic [`VPE_CH-1:0][`VPE_W_BITS-1:0]  i_act,
    input  wire logic [`VPE_IDX_BITS-1:0]             i_len,
    output logic [`VPE_IDX_BITS-1:0]                  o_win_idx,
    output vpe_pkg::scan_out_t                        o_scan
);

    localparam int SEL_BITS = $clog2(`VPE_WIN);
    localparam int IDX_W = `VPE_IDX_BITS;
    localparam logic [`VPE_IDX_BITS-1:0] WIN_STEP = IDX_W'(`VPE_WIN);

    vpe_pkg::scan_state_e      state_q;
    logic [`VPE_IDX_BITS-1:0]  idx_q;
    vpe_pkg::scan_out_t        scan_q;
    logic                      found;
    logic [SEL_BITS-1:0]       sel;
    logic [`VPE_IDX_BITS-1:0]  step;
    logic                      at_end;
    vpe_pkg::entry_t           pick;
    vpe_pkg::item_t            nxt_item;

    // first valid entry wins, so walk from the top down
    always_comb begin
        found = 1'b0;
        sel   = '0;
        for (int k = `VPE_WIN - 1; k >= 0; k--) begin
            if (i_window[k].valid) begin
                found = 1'b1;
                sel   = SEL_BITS'(k);
            end
        end
    end

    // skip past the pick, or the whole window when empty
    assign step   = found ? IDX_W'(sel) + 1'b1 : WIN_STEP;
    assign at_end = idx_q >= i_len;
    assign pick   = i_window[sel];

    assign nxt_item = '{
        weight: pick.weight,
        act:    i_act[pick.pos],  // activation by channel position
        addr:   pick.addr
    };

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= vpe_pkg::S_IDLE;
            idx_q   <= '0;
            scan_q  <= '0;
        end else begin
            scan_q.item_valid <= 1'b0;
            scan_q.done       <= 1'b0;
            case (state_q)
                vpe_pkg::S_IDLE: begin
                    if (i_start) begin
                        state_q <= vpe_pkg::S_RUN;
                        idx_q   <= '0;
                    end
                end
                vpe_pkg::S_RUN: begin
                    if (at_end) begin
                        scan_q.done <= 1'b1;
                        state_q     <= vpe_pkg::S_IDLE;
                    end else begin
                        scan_q.item_valid <= found;
                        if (found) begin
                            scan_q.item <= nxt_item;
                        end
                        idx_q <= idx_q + step;
                    end
                end
                default: state_q <= vpe_pkg::S_IDLE;
            endcase
        end
    end

    assign o_win_idx = idx_q;
    assign o_scan    = scan_q;

endmodule

`default_nettype wire

//--- logic/vpe_group_pack.sv
`default_nettype none

`include "vpe_defs.svh"

module vpe_group_pack (
    input  wire logic                i_clk,
    input  wire logic                i_rst_n,
    input  wire vpe_pkg::scan_out_t  i_scan,
    output vpe_pkg::group_t          o_right_group,
    output vpe_pkg::group_t          o_left_group,
    output logic                     o_right_ready,
    output logic                     o_left_ready,
    output logic                     o_finish
);

    localparam int SLOT_BITS = $clog2(`VPE_GROUP);
    localparam logic [SLOT_BITS-1:0] LAST_SLOT = SLOT_BITS'(`VPE_GROUP - 1);

    vpe_pkg::bank_e          bank_q;
    logic [SLOT_BITS-1:0]    slot_q;
    vpe_pkg::group_t         right_q;
    vpe_pkg::group_t         left_q;
    logic                    right_rdy_q;
    logic                    left_rdy_q;
    logic                    finish_q;
    vpe_pkg::group_t         cur_grp;
    vpe_pkg::group_t         nxt_grp;
    logic                    bank_wr;
    logic                    grp_done;
    logic                    partial;

    assign cur_grp  = (bank_q == vpe_pkg::BANK_RIGHT) ? right_q : left_q;
    assign partial  = i_scan.done && (slot_q != '0);
    assign bank_wr  = i_scan.item_valid || partial;
    assign grp_done = (i_scan.item_valid && (slot_q == LAST_SLOT)) || partial;

    // next contents of the active bank
    always_comb begin
        nxt_grp = cur_grp;
        if (i_scan.item_valid) begin
            nxt_grp.slot[slot_q] = i_scan.item;
        end else if (i_scan.done) begin
            for (int k = 0; k < `VPE_GROUP; k++) begin
                if (k >= int'(slot_q)) begin  // address left as is
                    nxt_grp.slot[k].weight = '0;
                    nxt_grp.slot[k].act    = '0;
                end
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bank_q      <= vpe_pkg::BANK_RIGHT;
            slot_q      <= '0;
            right_q     <= '0;
            left_q      <= '0;
            right_rdy_q <= 1'b0;
            left_rdy_q  <= 1'b0;
            finish_q    <= 1'b0;
        end else begin
            right_rdy_q <= grp_done && (bank_q == vpe_pkg::BANK_RIGHT);
            left_rdy_q  <= grp_done && (bank_q == vpe_pkg::BANK_LEFT);
            finish_q    <= i_scan.done;

            if (bank_wr) begin
                if (bank_q == vpe_pkg::BANK_RIGHT) begin
                    right_q <= nxt_grp;
                end else begin
                    left_q <= nxt_grp;
                end
            end

            if (i_scan.item_valid) begin
                if (slot_q == LAST_SLOT) begin  // group full, flip banks
                    slot_q <= '0;
                    bank_q <= (bank_q == vpe_pkg::BANK_RIGHT) ? vpe_pkg::BANK_LEFT
                                                              : vpe_pkg::BANK_RIGHT;
                end else begin
                    slot_q <= slot_q + 1'b1;
                end
            end else if (i_scan.done) begin
                // next run starts on the right bank again
                slot_q <= '0;
                bank_q <= vpe_pkg::BANK_RIGHT;
            end
        end
    end

    assign o_right_group = right_q;
    assign o_left_group  = left_q;
    assign o_right_ready = right_rdy_q;
    assign o_left_ready  = left_rdy_q;
    assign o_finish      = finish_q;

endmodule

`default_nettype wire

//--- logic/vpe_top.sv
`default_nettype none

`include "vpe_defs.svh"

module vpe_top (
    input  wire logic                           i_clk,
    input  wire logic                           i_rst_n,
    // host load port, AXI4-Lite write only
    input  wire logic                           i_awvalid,
    input  wire logic [`VPE_AXI_ADDR_BITS-1:0]  i_awaddr,
    output logic                                o_awready,
    input  wire logic                           i_wvalid,
    input  wire logic [31:0]                    i_wdata,
    output logic                                o_wready,
    output logic                                o_bvalid,
    input  wire logic                           i_bready,
    // group outputs, no back-pressure
    output vpe_pkg::group_t                     o_right_group,
    output vpe_pkg::group_t                     o_left_group,
    output logic                                o_right_ready,
    output logic                                o_left_ready,
    output logic                                o_finish
);

    logic [`VPE_IDX_BITS-1:0]             win_idx;
    vpe_pkg::entry_t [`VPE_WIN-1:0]       window;
    logic [`VPE_CH-1:0][`VPE_W_BITS-1:0]  act;
    logic [`VPE_IDX_BITS-1:0]             len;
    logic                                 start;
    vpe_pkg::scan_out_t                   scan;

    vpe_cfg_slave cfg_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_awvalid (i_awvalid),
        .i_awaddr  (i_awaddr),
        .i_wvalid  (i_wvalid),
        .i_wdata   (i_wdata),
        .i_bready  (i_bready),
        .o_awready (o_awready),
        .o_wready  (o_wready),
        .o_bvalid  (o_bvalid),
        .i_win_idx (win_idx),
        .o_window  (window),
        .o_act     (act),
        .o_len     (len),
        .o_start   (start)
    );

    vpe_window_scan scan_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_start   (start),
        .i_window  (window),
        .i_act     (act),
        .i_len     (len),
        .o_win_idx (win_idx),
        .o_scan    (scan)
    );

    vpe_group_pack pack_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_scan        (scan),
        .o_right_group (o_right_group),
        .o_left_group  (o_left_group),
        .o_right_ready (o_right_ready),
        .o_left_ready  (o_left_ready),
        .o_finish      (o_finish)
    );

endmodule

`default_nettype wire

//--- bench/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;  // period 10
    end

endmodule

`default_nettype wire

//--- bench/tb_top.sv
`default_nettype none

`include "vpe_defs.svh"

module tb_top;

    localparam int RUNS = 8;

    logic                           clk;
    logic                           rst_n;
    logic                           awvalid;
    logic                           wvalid;
    logic                           bready;
    logic [`VPE_AXI_ADDR_BITS-1:0]  awaddr;
    logic [31:0]                    wdata;
    logic                           awready;
    logic                           wready;
    logic                           bvalid;
    vpe_pkg::group_t                right_group;
    vpe_pkg::group_t                left_group;
    logic                           right_ready;
    logic                           left_ready;
    logic                           finish;

    logic [31:0]                    rng_state;
    int                             run_len [RUNS];
    int                             limit;
    int                             cycles = 0;
    int                             runs_started;
    int                             finish_count = 0;
    vpe_pkg::group_t                exp_grp [$];
    int                             exp_fill [$];
    logic                           exp_left [$];
    logic                           last_partial;
    logic [`VPE_W_BITS-1:0]         ent_w [`VPE_DEPTH];
    logic [`VPE_POS_BITS-1:0]       ent_pos [`VPE_DEPTH];
    logic [20:0]                    ent_addr [`VPE_DEPTH];
    logic                           ent_v [`VPE_DEPTH];
    logic [`VPE_W_BITS-1:0]         act_v [`VPE_CH];

    tb_clk_gen clk_gen_i (.o_clk(clk));

    vpe_top dut_i (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_awvalid     (awvalid),
        .i_awaddr      (awaddr),
        .o_awready     (awready),
        .i_wvalid      (wvalid),
        .i_wdata       (wdata),
        .o_wready      (wready),
        .o_bvalid      (bvalid),
        .i_bready      (bready),
        .o_right_group (right_group),
        .o_left_group  (left_group),
        .o_right_ready (right_ready),
        .o_left_ready  (left_ready),
        .o_finish      (finish)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;  // LCG step
        return rng_state;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            stop_on_error($sformatf("FAIL t=%0t %s got 0x%0h expected 0x%0h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_group(input vpe_pkg::group_t got, input vpe_pkg::group_t exp,
                               input int fill);
        for (int k = 0; k < `VPE_GROUP; k++) begin
            check_value($sformatf("slot%0d.weight", k), 32'(got.slot[k].weight),
                        32'(exp.slot[k].weight));
            check_value($sformatf("slot%0d.act", k), 32'(got.slot[k].act),
                        32'(exp.slot[k].act));
            if (k < fill) begin  // padded slots keep a stale address
                check_value($sformatf("slot%0d.addr", k), 32'(got.slot[k].addr),
                            32'(exp.slot[k].addr));
            end
        end
    endtask

    task automatic axi_write(input logic [`VPE_AXI_ADDR_BITS-1:0] addr,
                             input logic [31:0] data);
        int   stalls;
        logic acked;
        stalls  = 0;
        acked   = 1'b0;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        #1;
        check_value("o_awready", 32'(awready), 32'h1);
        check_value("o_wready", 32'(wready), 32'h1);
        @(negedge clk);
        check_value("o_bvalid", 32'(bvalid), 32'h1);  // accepted on the edge just passed
        check_value("o_awready", 32'(awready), 32'h0);  // response still pending
        check_value("o_wready", 32'(wready), 32'h0);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        // bready stalls, at most two per write
        while (!acked) begin
            if (stalls < 2 && ((next_rand() >> 16) % 32'd4) == 32'd0) begin
                bready = 1'b0;
                stalls++;
            end else begin
                bready = 1'b1;
                acked  = 1'b1;
            end
            @(negedge clk);
            check_value("o_bvalid", 32'(bvalid), 32'(!acked));
        end
        bready = 1'b0;
    endtask

    // window rule on the loaded list, then groups of three from the right bank
    task automatic build_model(input int len);
        vpe_pkg::item_t  items [$];
        vpe_pkg::item_t  it;
        vpe_pkg::group_t grp;
        int              idx;
        int              sel;
        int              n;
        logic            left;
        idx = 0;
        while (idx < len) begin
            sel = -1;
            for (int k = `VPE_WIN - 1; k >= 0; k--) begin
                if (idx + k < len) begin
                    if (ent_v[idx + k]) begin
                        sel = k;
                    end
                end
            end
            if (sel >= 0) begin
                it.weight = ent_w[idx + sel];
                it.act    = act_v[ent_pos[idx + sel]];
                it.addr   = ent_addr[idx + sel];
                items.push_back(it);
                idx += sel + 1;
            end else begin
                idx += `VPE_WIN;  // empty window
            end
        end
        grp = '0;
        n = 0;
        left = 1'b0;
        last_partial = 1'b0;
        foreach (items[i]) begin
            grp.slot[n] = items[i];
            n++;
            if (n == `VPE_GROUP || i == items.size() - 1) begin
                exp_grp.push_back(grp);
                exp_fill.push_back(n);
                exp_left.push_back(left);
                last_partial = (n < `VPE_GROUP);
                left = !left;
                grp = '0;
                n = 0;
            end
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            assert (!(right_ready && left_ready))
                else stop_on_error("both banks signaled ready in the same cycle");
            if (right_ready || left_ready) begin
                assert (finish_count < runs_started && exp_grp.size() > 0)
                    else stop_on_error("a ready pulse came that the model does not expect");
                check_value("o_left_ready", 32'(left_ready), 32'(exp_left[0]));
                check_group(left_ready ? left_group : right_group, exp_grp[0], exp_fill[0]);
                void'(exp_grp.pop_front());
                void'(exp_fill.pop_front());
                void'(exp_left.pop_front());
            end
            if (finish) begin
                assert (finish_count < runs_started)
                    else stop_on_error("finish pulsed while no run was active");
                assert (exp_grp.size() == 0)
                    else stop_on_error("finish came before all expected groups were sent");
                check_value("ready_with_finish", 32'(right_ready || left_ready),
                            32'(last_partial));
                finish_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        assert (cycles < limit)
            else stop_on_error("timeout, the runs did not finish within the cycle limit");
    end

    initial begin
        int len;
        int pct;
        rng_state    = 32'h22e8_f808;
        rst_n        = 1'b0;
        awvalid      = 1'b0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        awaddr       = '0;
        wdata        = '0;
        runs_started = 0;
        last_partial = 1'b0;
        limit        = 0;
        // lengths drawn up front to size the timeout
        for (int r = 0; r < RUNS; r++) begin
            if (r == 0) begin
                run_len[r] = 0;
            end else if (r == 2) begin
                run_len[r] = `VPE_DEPTH;
            end else begin
                run_len[r] = int'((next_rand() >> 8) % 32'd65);
            end
            limit += (2 * run_len[r] + 11) * 4 + run_len[r] + 10;
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("o_right_ready", 32'(right_ready), 32'h0);
        check_value("o_left_ready", 32'(left_ready), 32'h0);
        check_value("o_finish", 32'(finish), 32'h0);
        check_value("o_bvalid", 32'(bvalid), 32'h0);
        for (int r = 0; r < RUNS; r++) begin
            len = run_len[r];
            pct = (r == 1) ? 0 : 40;  // run 1 holds no valid entry
            for (int i = 0; i < len; i++) begin
                ent_w[i]    = 16'(next_rand() >> 8);
                ent_pos[i]  = 3'(next_rand() >> 20);
                ent_addr[i] = 21'(next_rand() >> 4);
                ent_v[i]    = ((next_rand() >> 8) % 32'd100) < 32'(pct);
            end
            for (int c = 0; c < `VPE_CH; c++) begin
                act_v[c] = 16'(next_rand() >> 12);
            end
            build_model(len);
            for (int i = 0; i < len; i++) begin
                axi_write(12'(`VPE_ENTRY_BASE + 8 * i), {ent_v[i], 12'h000, ent_pos[i], ent_w[i]});
                axi_write(12'(`VPE_ENTRY_BASE + 8 * i + 4), {11'h000, ent_addr[i]});
            end
            for (int c = 0; c < `VPE_CH; c++) begin
                axi_write(12'(`VPE_ACT_BASE + 4 * c), {16'h0000, act_v[c]});
            end
            axi_write(12'h308, next_rand());  // unmapped
            axi_write(`VPE_LEN_ADDR, 32'(len));
            runs_started++;
            axi_write(`VPE_START_ADDR, 32'h1);
            while (finish_count < runs_started) begin
                @(negedge clk);
            end
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+logic
logic/vpe_pkg.sv
logic/vpe_cfg_slave.sv
logic/vpe_window_scan.sv
logic/vpe_group_pack.sv
logic/vpe_top.sv
bench/tb_clk_gen.sv
bench/tb_top.sv

//--- run.sh
#!/bin/sh
# build the encoder testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f --top-module tb_top -o tb_top_sim
./obj_dir/tb_top_sim
